// File: hw/l2_cache_pkg.sv
// Shared definitions for the L2 read cache
// Line geometry constants, vector typedefs and controller state encoding
package l2_cache_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;

	// Beat and line geometry
	localparam int BEAT_BYTES = DATA_W / 8;
	localparam int LINE_BEATS = 16;
	localparam int LINE_BYTES = LINE_BEATS * BEAT_BYTES;

	// Address split
	localparam int BEAT_LSB = $clog2(BEAT_BYTES);
	localparam int LINE_LSB = $clog2(LINE_BYTES);

	// Refill always fetches a full line
	localparam int MEM_BURST_LEN = LINE_BEATS - 1;

	// Byte address
	typedef logic [ADDR_W-1:0] addr_t;

	// One beat of line data
	typedef logic [DATA_W-1:0] data_t;

	// Beat index within a line
	typedef logic [$clog2(LINE_BEATS)-1:0] beat_t;

	// Burst length field, beats minus one
	typedef logic [7:0] len_t;

	// Controller states
	typedef enum logic [2:0] {
		IDLE,
		TAG_CHECK,
		REFILL,
		RESP_IL1,
		RESP_DL1,
		FENCE
	} l2_state_e;

endpackage

// File: hw/l2_tag_array.sv
// Tag store with per way valid bits
// Hit detection, victim choice by free way search or LFSR
`timescale 1ns/10ps

module l2_tag_array import l2_cache_pkg::*; #(
	parameter int WAYS = 4,
	parameter int SETS = 32
) (
	input  logic                    CLK,
	input  logic                    rst,
	input  addr_t                   req_addr,
	input  logic                    alloc,
	input  logic                    flush,
	output logic                    hit,
	output logic [$clog2(WAYS)-1:0] hit_way,
	output logic [$clog2(WAYS)-1:0] fill_way
);

	localparam int WAY_W = $clog2(WAYS);
	localparam int SET_W = $clog2(SETS);
	localparam int TAG_W = ADDR_W - LINE_LSB - SET_W;

	// Tag and valid storage
	logic [TAG_W-1:0] tag_mem [WAYS][SETS];
	logic [WAYS-1:0]  valid_q [SETS];

	// Lookup fields of the latched address
	logic [SET_W-1:0] set_idx;
	logic [TAG_W-1:0] tag_in;

	logic [WAYS-1:0]  hit_vec;
	logic [WAY_W-1:0] free_way;
	logic             set_full;
	logic [WAY_W-1:0] victim;
	logic [15:0]      lfsr;

	assign set_idx = req_addr[LINE_LSB +: SET_W];
	assign tag_in  = req_addr[ADDR_W-1 -: TAG_W];

	// Compare every way of the set
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			hit_vec[w] = valid_q[set_idx][w] && (tag_mem[w][set_idx] == tag_in);
			if (hit_vec[w])
				hit_way = WAY_W'(w);
		end
	end

	assign hit = |hit_vec;

	// Lowest numbered invalid way, scanning down so way 0 is found last
	always_comb begin
		free_way = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!valid_q[set_idx][w])
				free_way = WAY_W'(w);
		end
	end

	assign set_full = &valid_q[set_idx];
	assign victim   = set_full ? lfsr[WAY_W-1:0] : free_way;

	// Valid bits and the free running LFSR
	always_ff @(posedge CLK) begin
		if (rst || flush) begin
			for (int s = 0; s < SETS; s++)
				valid_q[s] <= '0;
		end else if (alloc) begin
			valid_q[set_idx][victim] <= 1'b1;
		end
		if (rst)
			lfsr <= 16'hace1;
		else
			// Taps 16, 14, 13, 11
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
	end

	// New tag and the chosen way for the refill
	always_ff @(posedge CLK) begin
		if (alloc) begin
			tag_mem[victim][set_idx] <= tag_in;
			fill_way                 <= victim;
		end
	end

	// Controller only allocates after a miss
	a_alloc_miss: assert property (@(posedge CLK) disable iff (rst) alloc |-> !hit)
		else $error("Allocation requested for an address that hits");

endmodule

// File: hw/l2_data_array.sv
// Line data storage per way and set
// Refill beat write, combinational beat read for the active L1 port
`timescale 1ns/10ps

module l2_data_array import l2_cache_pkg::*; #(
	parameter int WAYS = 4,
	parameter int SETS = 32
) (
	input  logic                    CLK,
	input  addr_t                   req_addr,
	input  logic [$clog2(WAYS)-1:0] fill_way,
	input  logic                    beat_we,
	input  beat_t                   beat_idx,
	input  data_t                   beat_data,
	input  logic [$clog2(WAYS)-1:0] hit_way,
	input  logic                    serve_dl1,
	input  beat_t                   il1_beat,
	input  beat_t                   dl1_beat,
	output data_t                   rd_data
);

	localparam int SET_W = $clog2(SETS);

	// One beat per way, set and beat index
	data_t line_mem [WAYS][SETS][LINE_BEATS];

	logic [SET_W-1:0] set_idx;
	beat_t            rd_beat;

	assign set_idx = req_addr[LINE_LSB +: SET_W];

	// Refill lands in the way chosen at allocation
	always_ff @(posedge CLK) begin
		if (beat_we)
			line_mem[fill_way][set_idx][beat_idx] <= beat_data;
	end

	// Beat index of the port being served
	assign rd_beat = serve_dl1 ? dl1_beat : il1_beat;
	assign rd_data = line_mem[hit_way][set_idx][rd_beat];

endmodule

// File: hw/l2_refill.sv
// Memory refill engine
// Line aligned read address issue and beat by beat line fill
`timescale 1ns/10ps

module l2_refill import l2_cache_pkg::*; (
	input  logic  CLK,
	input  logic  rst,
	input  logic  refill_start,
	input  addr_t req_addr,
	input  logic  mem_arready,
	input  data_t mem_rdata,
	input  logic  mem_rlast,
	input  logic  mem_rvalid,
	output addr_t mem_araddr,
	output len_t  mem_arlen,
	output logic  mem_arvalid,
	output logic  mem_rready,
	output logic  beat_we,
	output beat_t beat_idx,
	output data_t beat_data,
	output logic  refill_done
);

	logic beat_hs;

	// req_addr stays put for the whole refill
	assign mem_araddr = {req_addr[ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
	assign mem_arlen  = len_t'(MEM_BURST_LEN);

	assign beat_hs = mem_rvalid && mem_rready;

	always_ff @(posedge CLK) begin
		if (rst) begin
			mem_arvalid <= 1'b0;
			mem_rready  <= 1'b0;
			beat_idx    <= '0;
		end else begin
			if (refill_start) begin
				mem_arvalid <= 1'b1;
				beat_idx    <= '0;
			end else if (mem_arvalid && mem_arready) begin
				// Address taken, open the data channel
				mem_arvalid <= 1'b0;
				mem_rready  <= 1'b1;
			end
			if (beat_hs) begin
				beat_idx <= beat_idx + beat_t'(1);
				if (mem_rlast)
					mem_rready <= 1'b0;
			end
		end
	end

	// Every accepted beat goes straight into the data array
	assign beat_we     = beat_hs;
	assign beat_data   = mem_rdata;
	assign refill_done = beat_hs && mem_rlast;

	// Memory must return exactly one full line
	a_rlast_16: assert property (@(posedge CLK) disable iff (rst)
		beat_hs |-> (mem_rlast == (beat_idx == beat_t'(LINE_BEATS - 1))))
		else $error("Memory rlast not on the 16th refill beat");

endmodule

// File: hw/l2_l1_read_port.sv
// Burst responder for one L1 read port
// Address accept, beat counter, rlast and end of burst pulse
`timescale 1ns/10ps

module l2_l1_read_port import l2_cache_pkg::*; (
	input  logic  CLK,
	input  logic  rst,
	input  logic  start,
	input  addr_t araddr,
	input  len_t  arlen,
	input  logic  rready,
	input  data_t rd_data,
	output logic  arready,
	output logic  rvalid,
	output logic  rlast,
	output data_t rdata,
	output beat_t rd_beat,
	output logic  done
);

	beat_t start_beat;
	beat_t beat_cnt;
	beat_t last_beat;

	// First beat comes from the request offset within the line
	assign start_beat = araddr[BEAT_LSB +: $bits(beat_t)];

	always_ff @(posedge CLK) begin
		if (rst) begin
			arready   <= 1'b0;
			rvalid    <= 1'b0;
			beat_cnt  <= '0;
			last_beat <= '0;
		end else begin
			// Single cycle address accept
			arready <= start;
			if (start) begin
				rvalid    <= 1'b1;
				beat_cnt  <= start_beat;
				last_beat <= start_beat + beat_t'(arlen);
			end else if (rvalid && rready) begin
				// Advance only on an accepted beat
				if (rlast)
					rvalid <= 1'b0;
				else
					beat_cnt <= beat_cnt + beat_t'(1);
			end
		end
	end

	assign rlast   = rvalid && (beat_cnt == last_beat);
	assign rd_beat = beat_cnt;

	// Data array output for the current beat
	assign rdata = rd_data;

	// Burst ends with the rlast handshake
	assign done = rvalid && rready && rlast;

	// Stalled beat must not change under the requester
	a_hold: assert property (@(posedge CLK) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
		else $error("Read beat changed while rready was low");

	// Only bursts that stay inside one line are supported
	a_in_line: assert property (@(posedge CLK) disable iff (rst)
		start |-> (int'(start_beat) + int'(arlen)) < LINE_BEATS)
		else $error("Read burst crosses a line boundary");

endmodule

// File: hw/l2_ctrl_fsm.sv
// Cache controller
// Request arbitration, request address latch, fence pending flag, state machine
`timescale 1ns/10ps

module l2_ctrl_fsm import l2_cache_pkg::*; (
	input  logic  CLK,
	input  logic  rst,
	input  logic  l2c_fence,
	input  logic  il1_arvalid,
	input  addr_t il1_araddr,
	input  logic  dl1_arvalid,
	input  addr_t dl1_araddr,
	input  logic  hit,
	input  logic  refill_done,
	input  logic  il1_done,
	input  logic  dl1_done,
	output addr_t req_addr,
	output logic  alloc,
	output logic  flush,
	output logic  refill_start,
	output logic  il1_start,
	output logic  dl1_start,
	output logic  serve_dl1
);

	l2_state_e state;
	l2_state_e state_nxt;
	logic      fence_pend;
	logic      take_req;

	// A new request is only accepted from IDLE with no fence waiting
	assign take_req = (state == IDLE) && !fence_pend && (il1_arvalid || dl1_arvalid);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				// Fence first, then any L1 request
				if (fence_pend)
					state_nxt = FENCE;
				else if (il1_arvalid || dl1_arvalid)
					state_nxt = TAG_CHECK;
			end
			TAG_CHECK: begin
				if (!hit)
					state_nxt = REFILL;
				else if (serve_dl1)
					state_nxt = RESP_DL1;
				else
					state_nxt = RESP_IL1;
			end
			// Line fetched, look it up again
			REFILL: if (refill_done) state_nxt = TAG_CHECK;
			RESP_IL1: if (il1_done) state_nxt = IDLE;
			RESP_DL1: if (dl1_done) state_nxt = IDLE;
			FENCE: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state      <= IDLE;
			fence_pend <= 1'b0;
			serve_dl1  <= 1'b0;
		end else begin
			state <= state_nxt;
			// A fence arriving during FENCE must not be lost
			if (l2c_fence)
				fence_pend <= 1'b1;
			else if (state == FENCE)
				fence_pend <= 1'b0;
			// il1 wins a tie
			if (take_req)
				serve_dl1 <= !il1_arvalid;
		end
	end

	// Requester holds the address until arready, so latch it once
	always_ff @(posedge CLK) begin
		if (take_req)
			req_addr <= il1_arvalid ? il1_araddr : dl1_araddr;
	end

	// Miss allocates a way and fetches the line
	assign alloc        = (state == TAG_CHECK) && !hit;
	assign refill_start = (state == TAG_CHECK) && !hit;

	// Hit hands the burst to the winning port
	assign il1_start = (state == TAG_CHECK) && hit && !serve_dl1;
	assign dl1_start = (state == TAG_CHECK) && hit && serve_dl1;

	// All valid bits drop at the end of the FENCE cycle
	assign flush = (state == FENCE);

	// Completion pulses only from the engine the state is waiting on
	a_done_state: assert property (@(posedge CLK) disable iff (rst)
		(!refill_done || state == REFILL) && (!il1_done || state == RESP_IL1)
		&& (!dl1_done || state == RESP_DL1))
		else $error("Completion pulse outside its refill or response state");

endmodule

// File: hw/l2_cache_top.sv
// L2 read cache top level
// Controller, tag and data arrays, memory refill engine, two L1 read ports
`timescale 1ns/10ps

module l2_cache_top import l2_cache_pkg::*; #(
	parameter int WAYS = 4,
	parameter int SETS = 32
) (
	input  logic  CLK,
	input  logic  rst,

	// Instruction side read channels
	input  addr_t il1_araddr,
	input  len_t  il1_arlen,
	input  logic  il1_arvalid,
	output logic  il1_arready,
	output data_t il1_rdata,
	output logic  il1_rlast,
	output logic  il1_rvalid,
	input  logic  il1_rready,

	// Data side read channels
	input  addr_t dl1_araddr,
	input  len_t  dl1_arlen,
	input  logic  dl1_arvalid,
	output logic  dl1_arready,
	output data_t dl1_rdata,
	output logic  dl1_rlast,
	output logic  dl1_rvalid,
	input  logic  dl1_rready,

	// Memory side refill channels
	output addr_t mem_araddr,
	output len_t  mem_arlen,
	output logic  mem_arvalid,
	input  logic  mem_arready,
	input  data_t mem_rdata,
	input  logic  mem_rlast,
	input  logic  mem_rvalid,
	output logic  mem_rready,

	// Invalidate all lines
	input  logic  l2c_fence
);

	localparam int WAY_W = $clog2(WAYS);

	// Controller outputs
	addr_t req_addr;
	logic  alloc;
	logic  flush;
	logic  refill_start;
	logic  il1_start;
	logic  dl1_start;
	logic  serve_dl1;

	// Tag lookup results
	logic             hit;
	logic [WAY_W-1:0] hit_way;
	logic [WAY_W-1:0] fill_way;

	// Refill beat stream into the data array
	logic  beat_we;
	beat_t beat_idx;
	data_t beat_data;
	logic  refill_done;

	// Port side read path
	beat_t il1_beat;
	beat_t dl1_beat;
	logic  il1_done;
	logic  dl1_done;
	data_t rd_data;

	l2_ctrl_fsm ctrl_i (
		.CLK(CLK), .rst(rst), .l2c_fence(l2c_fence),
		.il1_arvalid(il1_arvalid), .il1_araddr(il1_araddr),
		.dl1_arvalid(dl1_arvalid), .dl1_araddr(dl1_araddr),
		.hit(hit), .refill_done(refill_done), .il1_done(il1_done), .dl1_done(dl1_done),
		.req_addr(req_addr), .alloc(alloc), .flush(flush), .refill_start(refill_start),
		.il1_start(il1_start), .dl1_start(dl1_start), .serve_dl1(serve_dl1)
	);

	l2_tag_array #(.WAYS(WAYS), .SETS(SETS)) tag_i (
		.CLK(CLK), .rst(rst), .req_addr(req_addr), .alloc(alloc), .flush(flush),
		.hit(hit), .hit_way(hit_way), .fill_way(fill_way)
	);

	l2_data_array #(.WAYS(WAYS), .SETS(SETS)) data_i (
		.CLK(CLK), .req_addr(req_addr), .fill_way(fill_way),
		.beat_we(beat_we), .beat_idx(beat_idx), .beat_data(beat_data),
		.hit_way(hit_way), .serve_dl1(serve_dl1), .il1_beat(il1_beat), .dl1_beat(dl1_beat),
		.rd_data(rd_data)
	);

	l2_refill refill_i (
		.CLK(CLK), .rst(rst), .refill_start(refill_start), .req_addr(req_addr),
		.mem_arready(mem_arready), .mem_rdata(mem_rdata), .mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid), .mem_araddr(mem_araddr), .mem_arlen(mem_arlen),
		.mem_arvalid(mem_arvalid), .mem_rready(mem_rready), .beat_we(beat_we),
		.beat_idx(beat_idx), .beat_data(beat_data), .refill_done(refill_done)
	);

	// Instruction side responder
	l2_l1_read_port il1_port_i (
		.CLK(CLK), .rst(rst), .start(il1_start), .araddr(il1_araddr), .arlen(il1_arlen),
		.rready(il1_rready), .rd_data(rd_data), .arready(il1_arready), .rvalid(il1_rvalid),
		.rlast(il1_rlast), .rdata(il1_rdata), .rd_beat(il1_beat), .done(il1_done)
	);

	// Data side responder
	l2_l1_read_port dl1_port_i (
		.CLK(CLK), .rst(rst), .start(dl1_start), .araddr(dl1_araddr), .arlen(dl1_arlen),
		.rready(dl1_rready), .rd_data(rd_data), .arready(dl1_arready), .rvalid(dl1_rvalid),
		.rlast(dl1_rlast), .rdata(dl1_rdata), .rd_beat(dl1_beat), .done(dl1_done)
	);

endmodule

// File: verification/l2_mem_model.sv
// Memory read responder for the refill port
// Address pattern data with random arready and rvalid gaps
`timescale 1ns/10ps

module l2_mem_model import l2_cache_pkg::*; (
	input  logic  CLK,
	input  logic  rst,
	input  addr_t araddr,
	input  len_t  arlen,
	input  logic  arvalid,
	output logic  arready,
	output data_t rdata,
	output logic  rlast,
	output logic  rvalid,
	input  logic  rready
);

	addr_t beat_addr;
	int    beats_left;
	logic  held;

	initial begin
		arready    = 1'b0;
		rvalid     = 1'b0;
		rlast      = 1'b0;
		rdata      = '0;
		beat_addr  = '0;
		beats_left = 0;
		forever begin
			@(posedge CLK);
			// Handshakes of this edge
			held = !rst && rvalid && !rready;
			if (rst) begin
				beats_left = 0;
			end else if (arvalid && arready) begin
				beat_addr  = araddr;
				beats_left = int'(arlen) + 1;
			end else if (rvalid && rready) begin
				beat_addr  = beat_addr + addr_t'(BEAT_BYTES);
				beats_left = beats_left - 1;
			end
			#1;
			// Only one burst in flight
			arready = !rst && (beats_left == 0) && ($urandom_range(2) == 0);
			// A beat not yet taken stays on the bus
			if (!held)
				rvalid = (beats_left > 0) && ($urandom_range(3) != 0);
			// Upper half is the byte address, lower half its inverse
			rdata = {beat_addr, ~beat_addr};
			rlast = (beats_left == 1);
		end
	end

endmodule

// File: verification/tb_l2_cache.sv
// Testbench for the L2 read cache
// Clock, reset, burst read tasks, beat tracking assertions and timeout
`timescale 1ns/10ps

module tb_l2_cache import l2_cache_pkg::*; ();

	// About 40 bursts of under 100 cycles each, with wide margin
	localparam int TIMEOUT_CYCLES = 20000;
	// 32 sets of 128 byte lines
	localparam addr_t SET_STRIDE = 32'h0000_1000;

	logic CLK;
	logic rst;
	logic l2c_fence;

	// Index 0 is il1, index 1 is dl1
	logic [1:0]        arvalid;
	addr_t             araddr [2];
	len_t              arlen [2];
	logic [1:0]        rready;
	wire  [1:0]        arready;
	wire  [1:0]        rvalid;
	wire  [1:0]        rlast;
	wire  [DATA_W-1:0] rdata [2];

	// Memory side
	addr_t mem_araddr;
	len_t  mem_arlen;
	logic  mem_arvalid;
	logic  mem_arready;
	data_t mem_rdata;
	logic  mem_rlast;
	logic  mem_rvalid;
	logic  mem_rready;

	int cycles;
	int mem_reads;
	int ar_cycle [2];

	l2_cache_top dut_i (
		.CLK(CLK), .rst(rst),
		.il1_araddr(araddr[0]), .il1_arlen(arlen[0]), .il1_arvalid(arvalid[0]),
		.il1_arready(arready[0]), .il1_rdata(rdata[0]), .il1_rlast(rlast[0]),
		.il1_rvalid(rvalid[0]), .il1_rready(rready[0]),
		.dl1_araddr(araddr[1]), .dl1_arlen(arlen[1]), .dl1_arvalid(arvalid[1]),
		.dl1_arready(arready[1]), .dl1_rdata(rdata[1]), .dl1_rlast(rlast[1]),
		.dl1_rvalid(rvalid[1]), .dl1_rready(rready[1]),
		.mem_araddr(mem_araddr), .mem_arlen(mem_arlen), .mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready), .mem_rdata(mem_rdata), .mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
		.l2c_fence(l2c_fence)
	);

	l2_mem_model mem_i (
		.CLK(CLK), .rst(rst), .araddr(mem_araddr), .arlen(mem_arlen),
		.arvalid(mem_arvalid), .arready(mem_arready), .rdata(mem_rdata),
		.rlast(mem_rlast), .rvalid(mem_rvalid), .rready(mem_rready)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Expected memory content at a byte address
	function automatic data_t beat_pattern(addr_t a);
		return {a, ~a};
	endfunction

	task automatic value_error(string test, logic [63:0] expected, logic [63:0] actual);
		$display("Error: %s expected %h actual %h", test, expected, actual);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic run_error(string what);
		$display("Error: %s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// Cycle count, memory read count and the run limit
	always_ff @(posedge CLK) begin
		cycles <= cycles + 1;
		if (!rst && mem_arvalid && mem_arready)
			mem_reads <= mem_reads + 1;
		if (cycles >= TIMEOUT_CYCLES)
			run_error("run did not complete within the cycle limit");
	end

	// Memory reads fetch one aligned full line
	a_mem_align: assert property (@(posedge CLK) disable iff (rst)
		mem_arvalid && mem_arready |-> mem_araddr[LINE_LSB-1:0] == '0)
		else value_error("mem read address offset", 64'(0),
			64'($sampled(mem_araddr) & addr_t'(LINE_BYTES - 1)));
	a_mem_len: assert property (@(posedge CLK) disable iff (rst)
		mem_arvalid && mem_arready |-> mem_arlen == len_t'(LINE_BEATS - 1))
		else value_error("mem read length", 64'(LINE_BEATS - 1), 64'($sampled(mem_arlen)));

	// Expected address and remaining beats per L1 port
	for (genvar p = 0; p < 2; p++) begin : track_g
		localparam string PORT = (p == 0) ? "il1" : "dl1";
		addr_t beat_addr;
		int    beats_left;
		addr_t exp_addr;
		int    exp_left;
		logic  ar_hs;
		logic  r_hs;

		assign ar_hs = arvalid[p] && arready[p];
		assign r_hs  = rvalid[p] && rready[p];
		// First beat may share its cycle with arready
		assign exp_addr = ar_hs ? araddr[p] : beat_addr;
		assign exp_left = ar_hs ? int'(arlen[p]) + 1 : beats_left;

		always_ff @(posedge CLK) begin
			if (rst) begin
				beat_addr  <= '0;
				beats_left <= 0;
			end else if (r_hs) begin
				beat_addr  <= exp_addr + addr_t'(BEAT_BYTES);
				beats_left <= exp_left - 1;
			end else if (ar_hs) begin
				beat_addr  <= exp_addr;
				beats_left <= exp_left;
			end
		end

		a_data: assert property (@(posedge CLK) disable iff (rst)
			r_hs |-> rdata[p] == beat_pattern(exp_addr))
			else value_error({PORT, " read data"}, beat_pattern($sampled(exp_addr)),
				$sampled(rdata[p]));
		a_last: assert property (@(posedge CLK) disable iff (rst)
			r_hs |-> rlast[p] == (exp_left == 1))
			else value_error({PORT, " rlast"}, 64'($sampled(exp_left) == 1),
				64'($sampled(rlast[p])));
		a_extra: assert property (@(posedge CLK) disable iff (rst)
			rvalid[p] |-> exp_left > 0)
			else run_error({PORT, " presented a beat beyond the burst length"});
	end

	// Random back-pressure on both read data channels
	task automatic drive_rready();
		forever begin
			@(posedge CLK);
			#1;
			rready[0] = ($urandom_range(3) != 0);
			rready[1] = ($urandom_range(3) != 0);
		end
	endtask

	// One burst on a port; exp_reads below zero skips the miss count check
	task automatic read_burst(input int port, input addr_t addr, input int len,
			input int exp_reads);
		int   reads_before;
		logic accepted;
		logic done;
		reads_before  = mem_reads;
		araddr[port]  = addr;
		arlen[port]   = len_t'(len);
		arvalid[port] = 1'b1;
		done          = 1'b0;
		while (!done) begin
			@(posedge CLK);
			accepted = arready[port];
			done     = rvalid[port] && rready[port] && rlast[port];
			if (accepted)
				ar_cycle[port] = cycles;
			#1;
			if (accepted)
				arvalid[port] = 1'b0;
		end
		if (exp_reads >= 0)
			assert (mem_reads - reads_before == exp_reads)
				else value_error("mem read count", 64'(exp_reads), 64'(mem_reads - reads_before));
	endtask

	task automatic pulse_fence();
		l2c_fence = 1'b1;
		@(posedge CLK);
		#1;
		l2c_fence = 1'b0;
	endtask

	initial begin
		int k;
		int port;
		int off;
		int len;
		void'($urandom(32'h1e27));
		rst       = 1'b1;
		l2c_fence = 1'b0;
		arvalid   = 2'b00;
		rready    = 2'b00;
		for (int i = 0; i < 2; i++) begin
			araddr[i]   = '0;
			arlen[i]    = '0;
			ar_cycle[i] = 0;
		end
		fork
			drive_rready();
		join_none
		repeat (5) @(posedge CLK);
		#1;
		rst = 1'b0;
		assert (arready == 2'b00 && rvalid == 2'b00 && !mem_arvalid && !mem_rready)
			else run_error("L1 handshake outputs or mem arvalid or mem rready not low after reset");

		// Miss then hits in the same line from both ports
		read_burst(0, 32'h0000_1000, 15, 1);
		read_burst(0, 32'h0000_1010, 3, 0);
		read_burst(1, 32'h0000_1040, 7, 0);
		read_burst(1, 32'h0000_2078, 0, 1);

		// Fence drops every cached line
		pulse_fence();
		read_burst(0, 32'h0000_1000, 15, 1);
		read_burst(1, 32'h0000_2078, 0, 1);
		read_burst(1, 32'h0000_3000, 15, 1);

		// Tie between ports, il1 first
		fork
			read_burst(0, 32'h0000_1000, 3, 0);
			read_burst(1, 32'h0000_3000, 3, 0);
		join
		assert (ar_cycle[0] < ar_cycle[1])
			else run_error("dl1 got arready before il1 after a simultaneous request");

		// Six lines in one set fill the free ways then evict
		for (int i = 0; i < 6; i++)
			read_burst(i % 2, 32'h0001_0280 + addr_t'(i) * SET_STRIDE, 15, 1);
		for (int i = 0; i < 24; i++) begin
			k    = $urandom_range(5);
			port = $urandom_range(1);
			off  = $urandom_range(15);
			len  = $urandom_range(15 - off);
			read_burst(port, 32'h0001_0280 + addr_t'(k) * SET_STRIDE
				+ addr_t'(off * BEAT_BYTES), len, -1);
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

// File: l2_cache.f
hw/l2_cache_pkg.sv
hw/l2_tag_array.sv
hw/l2_data_array.sv
hw/l2_refill.sv
hw/l2_l1_read_port.sv
hw/l2_ctrl_fsm.sv
hw/l2_cache_top.sv
verification/l2_mem_model.sv
verification/tb_l2_cache.sv

// File: run_sim.sh
#!/bin/sh
# Build the L2 cache testbench with Verilator and run it
verilator --binary --timing --assert -j 0 --top-module tb_l2_cache \
	-f l2_cache.f -o sim_l2_cache \
	&& ./obj_dir/sim_l2_cache \
	|| { echo "simulation run did not pass"; exit 1; }
